// File: build.f
source/fetch_pkg.sv
source/fetch_fifo.sv
source/fetch_pc_unit.sv
source/fetch_ctrl.sv
source/fetch_top.sv
verif/decode_model.sv
verif/fetch_tb.sv

// File: run.sh
#!/bin/sh
# Build the fetch stage testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f build.f \
  && ./obj_dir/Vfetch_tb | tee /dev/stderr | grep -qx 'sim passed' \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// File: source/fetch_ctrl.sv
//----------------------------------------------------------
// Fetch control
// Request issue against credits, response sorting by epoch,
// squash sequencing and decode handshake
//----------------------------------------------------------

module fetch_ctrl (
  input  logic            clk,
  input  logic            rst,
  input  logic            squash,
  input  logic            imem_req_rdy,
  input  logic            imem_resp_val,
  input  logic            tag_epoch,
  input  logic            epoch,
  input  fetch_pkg::cnt_t buf_count,
  input  fetch_pkg::cnt_t inflight_count,
  input  logic            f_d_val,
  input  logic            f_d_rdy,
  output logic            imem_req_val,
  output logic            issue,
  output logic            redirect,
  output logic            flush_buf,
  output logic            tag_push,
  output logic            tag_pop,
  output logic            buf_push,
  output logic            buf_pop
);

  //----------------------------------------------------------
  // Run flag
  //----------------------------------------------------------

  // Low through reset, high from the first cycle after
  logic active;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
    end else begin
      active <= 1'b1;
    end
  end

  //----------------------------------------------------------
  // Credits
  //----------------------------------------------------------

  fetch_pkg::credit_t credits_used;
  logic               credit_ok;

  // Every slot is either in flight or buffered
  assign credits_used = fetch_pkg::credit_t'(inflight_count)
                      + fetch_pkg::credit_t'(buf_count);

  // Space is reserved before the request goes out
  assign credit_ok = (credits_used < fetch_pkg::credit_t'(fetch_pkg::buf_depth));

  //----------------------------------------------------------
  // Request issue
  //----------------------------------------------------------

  // Offer whenever a slot is free and no squash this cycle.
  // Credits only shrink while stalled, so the offer holds.
  assign imem_req_val = active && credit_ok && !squash;

  // Accepted request
  assign issue    = imem_req_val && imem_req_rdy;
  assign tag_push = issue;

  //----------------------------------------------------------
  // Response sorting
  //----------------------------------------------------------

  logic epoch_match;
  logic resp_keep;
  logic resp_drop;

  assign epoch_match = (tag_epoch == epoch);

  // Current epoch goes to the buffer
  assign resp_keep = imem_resp_val && epoch_match;
  // Older epoch is stale, only retire its tag
  assign resp_drop = imem_resp_val && !epoch_match;

  // Responses come back in order, one tag each
  assign tag_pop = resp_keep || resp_drop;

  // Push in the squash cycle is cancelled by the flush
  assign buf_push = resp_keep;

  //----------------------------------------------------------
  // Squash and decode handshake
  //----------------------------------------------------------

  // PC reload, epoch flip and buffer flush together
  assign redirect  = squash;
  assign flush_buf = squash;

  // No transfer to decode in the squash cycle
  assign buf_pop = f_d_val && f_d_rdy && !squash;

endmodule

// File: source/fetch_fifo.sv
//----------------------------------------------------------
// Fetch FIFO
// Circular buffer with fall-through head, flush and count
//----------------------------------------------------------

module fetch_fifo #(
  parameter type payload_t = fetch_pkg::fetch_entry_t
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            flush,
  input  logic            push,
  input  payload_t        push_data,
  input  logic            pop,
  output payload_t        pop_data,
  output logic            not_empty,
  output fetch_pkg::cnt_t count
);

  //----------------------------------------------------------
  // Storage and pointers
  //----------------------------------------------------------

  // Entry array
  payload_t mem [fetch_pkg::buf_depth];

  logic [fetch_pkg::ptr_bits-1:0] wr_ptr;
  logic [fetch_pkg::ptr_bits-1:0] rd_ptr;

  logic full;
  logic do_push;
  logic do_pop;

  assign not_empty = (count != '0);
  assign full      = (count == fetch_pkg::cnt_t'(fetch_pkg::buf_depth));

  // Flush wins over both push and pop
  assign do_pop  = pop && not_empty && !flush;
  // A full FIFO still takes a push when the head leaves
  assign do_push = push && !flush && (!full || do_pop);

  // Head entry visible while not empty
  assign pop_data = mem[rd_ptr];

  //----------------------------------------------------------
  // Write port
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  //----------------------------------------------------------
  // Pointer and count update
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own since depth is a power of two
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        // Both or neither leaves occupancy alone
        default: count <= count;
      endcase
    end
  end

endmodule

// File: source/fetch_pc_unit.sv
//----------------------------------------------------------
// Fetch PC unit
// Holds fetch PC and epoch, steps on issue, loads on redirect
//----------------------------------------------------------

module fetch_pc_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             issue,
  input  logic             redirect,
  input  fetch_pkg::addr_t branch_target,
  output fetch_pkg::addr_t pc,
  output logic             epoch
);

  //----------------------------------------------------------
  // Next PC selection
  //----------------------------------------------------------

  fetch_pkg::addr_t pc_plus4;
  fetch_pkg::addr_t pc_next;
  logic             epoch_next;

  // Sequential step, one word per request
  assign pc_plus4 = pc + fetch_pkg::addr_t'(4);

  always_comb begin
    pc_next    = pc;
    epoch_next = epoch;
    // Redirect beats issue
    if (redirect) begin
      pc_next    = branch_target;
      // New epoch marks older requests as stale
      epoch_next = ~epoch;
    end else if (issue) begin
      pc_next = pc_plus4;
    end
  end

  //----------------------------------------------------------
  // PC and epoch registers
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= fetch_pkg::reset_pc;
      epoch <= 1'b0;
    end else begin
      pc    <= pc_next;
      epoch <= epoch_next;
    end
  end

endmodule

// File: source/fetch_pkg.sv
//----------------------------------------------------------
// Fetch stage shared definitions
// Widths, reset address, buffer depth and payload types
//----------------------------------------------------------

package fetch_pkg;

  // Address and instruction widths
  localparam int addr_bits = 32;
  localparam int inst_bits = 32;

  // First fetch address after reset
  localparam logic [addr_bits-1:0] reset_pc = 32'h0000_0200;

  // Buffer capacity, also the cap on outstanding requests
  localparam int buf_depth = 4;
  localparam int cnt_bits  = 3;
  localparam int ptr_bits  = 2;

  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [inst_bits-1:0] inst_t;

  // Occupancy count, and a wider sum of two counts
  typedef logic [cnt_bits-1:0] cnt_t;
  typedef logic [cnt_bits:0]   credit_t;

  // Instruction buffer entry, pc in the upper half
  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_entry_t;

  // In-flight tag, one per issued request
  typedef struct packed {
    addr_t pc;
    logic  epoch;
  } tag_entry_t;

endpackage

// File: source/fetch_top.sv
//----------------------------------------------------------
// Fetch stage top
// Control, PC unit, in-flight tag FIFO and instruction buffer
//----------------------------------------------------------

module fetch_top (
  input  logic             clk,
  input  logic             rst,

  // Instruction memory
  output logic             imem_req_val,
  input  logic             imem_req_rdy,
  output fetch_pkg::addr_t imem_req_addr,
  input  logic             imem_resp_val,
  input  fetch_pkg::inst_t imem_resp_data,

  // Decode channel
  output logic             f_d_val,
  input  logic             f_d_rdy,
  output fetch_pkg::addr_t f_d_pc,
  output fetch_pkg::inst_t f_d_inst,
  input  logic             squash,
  input  fetch_pkg::addr_t branch_target
);

  //----------------------------------------------------------
  // Internal wires
  //----------------------------------------------------------

  logic issue;
  logic redirect;
  logic flush_buf;
  logic tag_push;
  logic tag_pop;
  logic buf_push;
  logic buf_pop;
  logic epoch;

  fetch_pkg::cnt_t inflight_count;
  fetch_pkg::cnt_t buf_count;

  fetch_pkg::tag_entry_t   tag_head;
  fetch_pkg::fetch_entry_t buf_head;

  // Buffer head goes straight to decode
  assign f_d_pc   = buf_head.pc;
  assign f_d_inst = buf_head.inst;

  //----------------------------------------------------------
  // Control
  //----------------------------------------------------------

  fetch_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .squash         (squash),
    .imem_req_rdy   (imem_req_rdy),
    .imem_resp_val  (imem_resp_val),
    .tag_epoch      (tag_head.epoch),
    .epoch          (epoch),
    .buf_count      (buf_count),
    .inflight_count (inflight_count),
    .f_d_val        (f_d_val),
    .f_d_rdy        (f_d_rdy),
    .imem_req_val   (imem_req_val),
    .issue          (issue),
    .redirect       (redirect),
    .flush_buf      (flush_buf),
    .tag_push       (tag_push),
    .tag_pop        (tag_pop),
    .buf_push       (buf_push),
    .buf_pop        (buf_pop)
  );

  // Request address is the fetch PC itself
  fetch_pc_unit u_pc (
    .clk           (clk),
    .rst           (rst),
    .issue         (issue),
    .redirect      (redirect),
    .branch_target (branch_target),
    .pc            (imem_req_addr),
    .epoch         (epoch)
  );

  //----------------------------------------------------------
  // In-flight tags, never flushed so stale ones drain
  //----------------------------------------------------------

  fetch_fifo #(
    .payload_t (fetch_pkg::tag_entry_t)
  ) u_tag_fifo (
    .clk       (clk),
    .rst       (rst),
    .flush     (1'b0),
    .push      (tag_push),
    .push_data ({imem_req_addr, epoch}),
    .pop       (tag_pop),
    .pop_data  (tag_head),
    .not_empty (),
    .count     (inflight_count)
  );

  //----------------------------------------------------------
  // Instruction buffer
  //----------------------------------------------------------

  // Entry pairs the tag pc with the returned word
  fetch_fifo #(
    .payload_t (fetch_pkg::fetch_entry_t)
  ) u_inst_buf (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush_buf),
    .push      (buf_push),
    .push_data ({tag_head.pc, imem_resp_data}),
    .pop       (buf_pop),
    .pop_data  (buf_head),
    .not_empty (f_d_val),
    .count     (buf_count)
  );

endmodule

// File: verif/decode_model.sv
//----------------------------------------------------------
// Decode-side model
// Checks the fetched pc/inst stream, drives back-pressure
// and squash pulses with random word-aligned targets
//----------------------------------------------------------

module decode_model #(
  parameter logic [31:0] mem_key = 32'h5a5a_0000
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             f_d_val,
  input  fetch_pkg::addr_t f_d_pc,
  input  fetch_pkg::inst_t f_d_inst,
  input  logic [15:0]      rand_bits,
  input  logic [1:0]       rdy_mode,
  input  logic             squash_en,
  input  logic             squash_now,
  output logic             f_d_rdy,
  output logic             squash,
  output fetch_pkg::addr_t branch_target,
  output int               xfer_count,
  output int               squash_count,
  output int               error_count
);
  timeunit 1ns;
  timeprecision 100ps;

  // Expected pc of the next transfer
  fetch_pkg::addr_t expect_pc;
  logic             check_bubble;
  logic             squash_now_q;
  logic             rdy_next;
  logic             squash_next;
  fetch_pkg::addr_t target_next;

  initial begin
    f_d_rdy       = 1'b0;
    squash        = 1'b0;
    branch_target = '0;
    error_count   = 0;
    expect_pc     = fetch_pkg::reset_pc;
    check_bubble  = 1'b0;
    squash_now_q  = 1'b0;
    rdy_next      = 1'b0;
    squash_next   = 1'b0;
    target_next   = '0;
  end

  //----------------------------------------------------------
  // Checks at mid-cycle where everything is settled
  //----------------------------------------------------------

  always @(negedge clk) begin
    if (rst) begin
      expect_pc    = fetch_pkg::reset_pc;
      check_bubble = 1'b0;
      xfer_count   <= 0;
      squash_count <= 0;
    end else begin
      // Buffer was flushed so nothing is offered yet
      if (check_bubble) begin
        assert (!f_d_val) else begin
          $display("Fail squash_bubble expected %b actual %b", 1'b0, f_d_val);
          error_count++;
        end
      end
      check_bubble = squash;
      // Squash cycle blocks the transfer and restarts the stream
      if (squash) begin
        expect_pc = branch_target;
        squash_count <= squash_count + 1;
      end else if (f_d_val && f_d_rdy) begin
        assert (f_d_pc == expect_pc) else begin
          $display("Fail stream_pc expected %h actual %h", expect_pc, f_d_pc);
          error_count++;
        end
        assert (f_d_inst == (f_d_pc ^ mem_key)) else begin
          $display("Fail stream_inst expected %h actual %h", f_d_pc ^ mem_key, f_d_inst);
          error_count++;
        end
        expect_pc = expect_pc + 32'd4;
        xfer_count <= xfer_count + 1;
      end
    end

    // Decisions for the next cycle
    case (rdy_mode)
      2'd0:    rdy_next = 1'b1;
      2'd1:    rdy_next = rand_bits[0];
      default: rdy_next = 1'b0;
    endcase
    // Random squash about one cycle in eight or one on request
    squash_next = !rst && !squash
                && ((squash_en && rand_bits[3:1] == 3'd0) || (squash_now && !squash_now_q));
    squash_now_q = squash_now;
    target_next  = 32'h0000_1000 + {18'd0, rand_bits[15:4], 2'b00};
  end

  // Drive just after the rising edge
  always @(posedge clk) begin
    #1;
    f_d_rdy       = rdy_next;
    squash        = squash_next;
    branch_target = target_next;
  end

endmodule

// File: verif/fetch_tb.sv
//----------------------------------------------------------
// Fetch stage testbench
// Clock, reset, instruction memory model and test phases
//----------------------------------------------------------

module fetch_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] mem_key    = 32'h5a5a_0000;
  localparam logic [31:0] lfsr_seed  = 32'ha48c;
  localparam int          wait_limit = 2000;

  logic clk;
  logic rst;
  logic imem_req_val;
  logic imem_req_rdy;
  logic imem_resp_val;
  logic f_d_val;
  logic f_d_rdy;
  logic squash;
  fetch_pkg::addr_t imem_req_addr;
  fetch_pkg::inst_t imem_resp_data;
  fetch_pkg::addr_t f_d_pc;
  fetch_pkg::inst_t f_d_inst;
  fetch_pkg::addr_t branch_target;

  // Phase controls that change mid-cycle only
  logic        mem_random;
  logic [1:0]  rdy_mode;
  logic        squash_en;
  logic        squash_now;
  logic [15:0] model_rand;
  logic [31:0] lfsr_state;

  int cyc;
  int outstanding;
  int tb_errors;
  int xfer_count;
  int squash_count;
  int dec_errors;
  int k;

  // Accepted requests waiting for their response
  logic [31:0] req_addr_q[$];
  int          req_due_q[$];
  logic        held_valid;
  logic [31:0] held_addr;
  logic        first_seen;

  fetch_top i_fetch_top (
    .clk (clk), .rst (rst),
    .imem_req_val (imem_req_val), .imem_req_rdy (imem_req_rdy),
    .imem_req_addr (imem_req_addr), .imem_resp_val (imem_resp_val),
    .imem_resp_data (imem_resp_data),
    .f_d_val (f_d_val), .f_d_rdy (f_d_rdy), .f_d_pc (f_d_pc), .f_d_inst (f_d_inst),
    .squash (squash), .branch_target (branch_target)
  );

  decode_model #(.mem_key (mem_key)) i_decode (
    .clk (clk), .rst (rst), .f_d_val (f_d_val), .f_d_pc (f_d_pc), .f_d_inst (f_d_inst),
    .rand_bits (model_rand), .rdy_mode (rdy_mode), .squash_en (squash_en),
    .squash_now (squash_now), .f_d_rdy (f_d_rdy), .squash (squash),
    .branch_target (branch_target), .xfer_count (xfer_count),
    .squash_count (squash_count), .error_count (dec_errors)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] next_random(input int nbits);
    logic [31:0] val;
    logic        lsb;
    int          i;
    val = '0;
    for (i = 0; i < nbits; i++) begin
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) lfsr_state = lfsr_state ^ 32'h8020_0003;
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  //----------------------------------------------------------
  // Memory model response driver
  //----------------------------------------------------------

  always @(posedge clk) begin : drive_memory
    logic [31:0] r;
    #1;
    cyc = cyc + 1;
    r = next_random(16);
    model_rand = r[15:0];
    r = mem_random ? next_random(1) : 32'd1;
    imem_req_rdy  = r[0];
    // Head response once its delay has passed
    imem_resp_val = 1'b0;
    if (req_due_q.size() > 0 && req_due_q[0] <= cyc) begin
      imem_resp_val  = 1'b1;
      imem_resp_data = req_addr_q[0] ^ mem_key;
      void'(req_due_q.pop_front());
      void'(req_addr_q.pop_front());
    end
  end

  //----------------------------------------------------------
  // Memory model request acceptance and checks
  //----------------------------------------------------------

  always @(negedge clk) begin : watch_memory
    int          next_out;
    logic [31:0] r;
    next_out = outstanding;
    if (rst) begin
      next_out = 0;
      assert (!imem_req_val && !f_d_val) else begin
        $display("Fail reset_quiet expected %b actual %b", 2'b00, {imem_req_val, f_d_val});
        tb_errors++;
      end
    end else begin
      if (!first_seen && imem_req_val) begin
        assert (imem_req_addr == fetch_pkg::reset_pc) else begin
          $display("Fail first_req expected %h actual %h", fetch_pkg::reset_pc, imem_req_addr);
          tb_errors++;
        end
        first_seen = 1'b1;
      end
      // Stalled request must hold its address
      if (held_valid && imem_req_val) begin
        assert (imem_req_addr == held_addr) else begin
          $display("Fail req_hold expected %h actual %h", held_addr, imem_req_addr);
          tb_errors++;
        end
      end
      held_valid = imem_req_val && !imem_req_rdy;
      held_addr  = imem_req_addr;
      if (imem_req_val && imem_req_rdy) begin
        r = next_random(2);
        req_addr_q.push_back(imem_req_addr);
        req_due_q.push_back(cyc + int'(r[1:0]) + 1);
        next_out++;
      end
      if (imem_resp_val) next_out--;
      assert (next_out <= fetch_pkg::buf_depth) else begin
        $display("Fail outstanding expected %0d actual %0d", fetch_pkg::buf_depth, next_out);
        tb_errors++;
      end
    end
    outstanding <= next_out;
  end

  //----------------------------------------------------------
  // Phase helpers
  //----------------------------------------------------------

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("sim failed");
    $finish;
  endtask

  task automatic set_mode(input logic mem_rnd, input logic [1:0] rdy, input logic sq);
    @(posedge clk);
    #5;
    mem_random = mem_rnd;
    rdy_mode   = rdy;
    squash_en  = sq;
  endtask

  task automatic wait_for_xfers(input int n, input string what);
    int target;
    int waited;
    target = xfer_count + n;
    waited = 0;
    while (xfer_count < target) begin
      @(negedge clk);
      waited++;
      if (waited > wait_limit) stop_on_timeout(what);
    end
  endtask

  task automatic wait_for_squashes(input int n, input string what);
    int target;
    int waited;
    target = squash_count + n;
    waited = 0;
    while (squash_count < target) begin
      @(negedge clk);
      waited++;
      if (waited > wait_limit) stop_on_timeout(what);
    end
  endtask

  // Wait until credits are spent and if full is set until nothing is in flight
  task automatic wait_for_stall(input logic full);
    int waited;
    waited = 0;
    @(negedge clk);
    while (imem_req_val || (full && outstanding != 0)) begin
      @(negedge clk);
      waited++;
      if (waited > wait_limit) stop_on_timeout("fetch to stall on credits");
    end
  endtask

  // One-cycle request to the decode model
  task automatic pulse_squash();
    @(posedge clk);
    #5 squash_now = 1'b1;
    @(posedge clk);
    #5 squash_now = 1'b0;
  endtask

  //----------------------------------------------------------
  // Test sequence
  //----------------------------------------------------------

  initial begin
    rst            = 1'b1;
    imem_req_rdy   = 1'b0;
    imem_resp_val  = 1'b0;
    imem_resp_data = '0;
    lfsr_state     = lfsr_seed;
    model_rand     = '0;
    mem_random     = 1'b0;
    rdy_mode       = 2'd0;
    squash_en      = 1'b0;
    squash_now     = 1'b0;
    cyc            = 0;
    tb_errors      = 0;
    held_valid     = 1'b0;
    held_addr      = '0;
    first_seen     = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;

    // Plain sequential stream
    wait_for_xfers(24, "sequential transfers");
    // Random stalls on memory and decode
    set_mode(1'b1, 2'd1, 1'b0);
    wait_for_xfers(60, "transfers under back-pressure");
    // Random squashes on top
    set_mode(1'b1, 2'd1, 1'b1);
    wait_for_squashes(8, "random squashes");
    wait_for_xfers(30, "transfers after random squashes");

    // Squash with decode stalled while in flight on even rounds and full on odd rounds
    for (k = 0; k < 6; k++) begin
      set_mode(1'b1, 2'd2, 1'b0);
      wait_for_stall(k[0]);
      pulse_squash();
      wait_for_squashes(1, "squash under load");
      set_mode(1'b1, 2'd0, 1'b0);
      wait_for_xfers(8, "transfers after squash under load");
    end

    repeat (4) @(posedge clk);
    $display("Errors: testbench %0d, decode %0d", tb_errors, dec_errors);
    if (tb_errors + dec_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
